/* hex_dump.sv */
`timescale 1ns/1ps
module hex_dump (
  input  logic                 clock,
  input  logic                 usb_rst,
  input  logic                 send_i,
  input  logic                 buf_empty_i,
  input  logic                 rd_valid_i,
  input  telem_pkg::log_word_t rd_word_i,
  output logic                 rd_credit_o,
  input  logic                 tx_credit_i,
  input  logic                 tx_idle_i,
  output logic                 tx_valid_o,
  output serial_pkg::byte_t    tx_byte_o,
  output logic                 busy_o
);

  localparam int TCW = $clog2(serial_pkg::UART_CREDITS + 1);

  telem_pkg::dump_state_e          state_q;
  logic [telem_pkg::LOG_WIDTH-1:0] word_q;
  logic                            have_q;    // Word loaded for this line
  logic [3:0]                      char_q;    // 0..7 digits, 8 CR, 9 LF
  logic [TCW-1:0]                  credit_q;
  logic                            emit_w;
  logic [3:0]                      nib_w;
  serial_pkg::byte_t               char_w;

  assign busy_o = (state_q != telem_pkg::DUMP_IDLE);
  assign emit_w = (state_q == telem_pkg::DUMP_EMIT) && have_q && (credit_q != '0);
  assign nib_w  = word_q[telem_pkg::LOG_WIDTH-1 -: 4];  // Top nibble goes first

  // Nibble to upper-case hex, or line end
  always_comb begin
    if (char_q == 4'd8) begin
      char_w = serial_pkg::ASCII_CR;
    end else if (char_q == 4'd9) begin
      char_w = serial_pkg::ASCII_LF;
    end else if (nib_w < 4'd10) begin
      char_w = serial_pkg::ASCII_ZERO + {4'h0, nib_w};
    end else begin
      char_w = serial_pkg::ASCII_UPPER_A + {4'h0, nib_w} - 8'd10;
    end
  end

  always_ff @(posedge clock) begin
    if (rd_valid_i) begin
      word_q <= rd_word_i;
    end else if (emit_w && char_q < 4'd8) begin
      word_q <= word_q << 4;
    end
    if (emit_w) begin
      tx_byte_o <= char_w;
    end
  end

  always_ff @(posedge clock) begin
    if (usb_rst) begin
      state_q     <= telem_pkg::DUMP_IDLE;
      have_q      <= 1'b0;
      char_q      <= 4'd0;
      credit_q    <= TCW'(serial_pkg::UART_CREDITS);
      rd_credit_o <= 1'b0;
      tx_valid_o  <= 1'b0;
    end else begin
      rd_credit_o <= 1'b0;
      tx_valid_o  <= emit_w;
      credit_q    <= credit_q - TCW'(emit_w) + TCW'(tx_credit_i);

      case (state_q)
        telem_pkg::DUMP_IDLE: begin
          if (send_i) begin
            state_q <= telem_pkg::DUMP_REQ;
          end
        end
        telem_pkg::DUMP_REQ: begin
          if (buf_empty_i) begin
            state_q <= telem_pkg::DUMP_DONE;  // Nothing left to print
          end else begin
            rd_credit_o <= 1'b1;  // Exactly one word at a time
            have_q      <= 1'b0;
            char_q      <= 4'd0;
            state_q     <= telem_pkg::DUMP_EMIT;
          end
        end
        telem_pkg::DUMP_EMIT: begin
          if (rd_valid_i) begin
            have_q <= 1'b1;
          end
          if (emit_w) begin
            char_q <= char_q + 4'd1;
            if (char_q == 4'd9) begin
              state_q <= telem_pkg::DUMP_REQ;
            end
          end
        end
        default: begin
          // Busy holds until the last stop bit is out
          if (credit_q == TCW'(serial_pkg::UART_CREDITS) && tx_idle_i) begin
            state_q <= telem_pkg::DUMP_IDLE;
          end
        end
      endcase
    end
  end

endmodule

/* project.f */
telem_pkg.sv
serial_pkg.sv
tlm_capture.sv
tlm_buffer.sv
hex_dump.sv
uart_tx.sv
usb_telemetry_core.sv
tb_usb_telemetry_core.sv

/* serial_pkg.sv */
package serial_pkg;

  typedef logic [7:0] byte_t;

  // Characters used by the hex dump
  localparam byte_t ASCII_CR      = 8'h0D;
  localparam byte_t ASCII_LF      = 8'h0A;
  localparam byte_t ASCII_ZERO    = 8'h30;
  localparam byte_t ASCII_UPPER_A = 8'h41;

  // Holding slots in the transmitter
  localparam int UART_CREDITS = 2;

  // 8N1 frame sequence
  typedef enum logic [1:0] {
    TX_IDLE  = 2'd0,
    TX_START = 2'd1,
    TX_DATA  = 2'd2,
    TX_STOP  = 2'd3
  } tx_state_e;

endpackage

/* tb_usb_telemetry_core.sv */
`timescale 1ns/1ps
module tb_usb_telemetry_core;

  localparam int DEPTH        = 16;
  localparam int BIT_CYCLES   = 4;
  localparam int DUMP_TIMEOUT = 20000;  // A full buffer takes about 6500 cycles

  logic        clock;
  logic        usb_rst;
  logic        enable_i;
  logic [19:0] change_i;
  logic [11:0] ignore_i;
  logic        send_i;
  logic        dump_busy_o;
  logic [4:0]  level_o;
  logic [7:0]  drop_count_o;
  logic        uart_tx_o;

  logic [31:0] model_q [$];  // Words the buffer should hold
  logic [7:0]  exp_q [$];    // Characters still due on the line
  logic [7:0]  rx_q [$];     // Characters decoded from the line
  logic [7:0]  model_drops;
  int unsigned seed;

  usb_telemetry_core #(
    .LOG_DEPTH (DEPTH),
    .BIT_CYCLES(BIT_CYCLES)
  ) u_dut (
    .clock, .usb_rst, .enable_i, .change_i, .ignore_i, .send_i,
    .dump_busy_o, .level_o, .drop_count_o, .uart_tx_o
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR: %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // Eight upper-case hex digits from the top nibble down and then CR LF
  function automatic logic [79:0] line_text(input logic [31:0] word);
    logic [79:0] text;
    logic [3:0]  nib;
    int          k;
    text = '0;
    for (k = 0; k < 8; k++) begin
      nib = word[31 - 4*k -: 4];
      text[79 - 8*k -: 8] = (nib < 4'd10) ? 8'h30 + nib : 8'h37 + nib;
    end
    text[15:8] = 8'h0D;
    text[7:0]  = 8'h0A;
    return text;
  endfunction

  task automatic wait_busy(input logic level, input int limit, input string what);
    int n;
    n = 0;
    while (dump_busy_o !== level && n < limit) begin
      @(negedge clock);
      n++;
    end
    if (dump_busy_o !== level) begin
      abort_run(what);
    end
  endtask

  // Drives one stimulus cycle and updates the model by the capture rule
  task automatic drive_step(input logic en, input logic [19:0] chg, input logic [11:0] ign);
    @(negedge clock);
    if (en && chg != change_i) begin
      if (model_q.size() < DEPTH) begin
        model_q.push_back({ign, chg});
      end else if (model_drops != 8'hFF) begin
        model_drops = model_drops + 8'd1;
      end
    end
    enable_i = en;
    change_i = chg;
    ignore_i = ign;
  endtask

  task automatic random_steps(input int steps, input int stop_at);
    logic [31:0] rnd;
    logic [19:0] chg;
    logic [11:0] ign;
    logic        en;
    int          i;
    for (i = 0; i < steps && model_q.size() < stop_at; i++) begin
      en  = ($urandom % 3) != 0;
      rnd = $urandom;
      ign = rnd[31:20];
      chg = change_i;  // A quarter of the steps touch only the side bits
      if ($urandom % 4 != 0) begin
        rnd = $urandom;
        chg = (rnd[19:0] == change_i) ? ~rnd[19:0] : rnd[19:0];
      end
      drive_step(en, chg, ign);
      repeat ($urandom % 3) @(negedge clock);
    end
  endtask

  task automatic queue_expected();
    logic [79:0] text;
    int          k;
    while (model_q.size() != 0) begin
      text = line_text(model_q.pop_front());
      for (k = 0; k < 10; k++) begin
        exp_q.push_back(text[79 - 8*k -: 8]);
      end
    end
  endtask

  task automatic run_dump(input logic poke_again);
    queue_expected();
    @(negedge clock);
    send_i = 1'b1;
    @(negedge clock);
    send_i = 1'b0;
    wait_busy(1'b1, 20, "dump_busy_o did not rise after a send request");
    if (poke_again) begin
      repeat (100) @(negedge clock);
      send_i = 1'b1;  // Must be ignored while busy
      @(negedge clock);
      send_i = 1'b0;
    end
    wait_busy(1'b0, DUMP_TIMEOUT, "Dump did not finish before the timeout");
    repeat (12 * BIT_CYCLES) begin
      @(negedge clock);
      check_value("dump_busy_o", dump_busy_o, 0);
    end
    check_value("pending characters", exp_q.size(), 0);
    check_value("level_o", level_o, 0);
  endtask

  // Decodes the line by sampling near the middle of each bit
  initial begin : line_decoder
    logic [7:0] rx_byte;
    int         i;
    forever begin
      @(negedge clock);
      if (!usb_rst && uart_tx_o === 1'b0) begin
        @(negedge clock);
        check_value("uart_tx_o start bit", uart_tx_o, 0);
        for (i = 0; i < 8; i++) begin
          repeat (BIT_CYCLES) @(negedge clock);
          rx_byte[i] = uart_tx_o;  // LSB first
        end
        repeat (BIT_CYCLES) @(negedge clock);
        check_value("uart_tx_o stop bit", uart_tx_o, 1);
        rx_q.push_back(rx_byte);
      end
    end
  end

  always @(posedge clock) begin : compare_bytes
    logic [7:0] got;
    if (rx_q.size() != 0) begin
      got = rx_q.pop_front();
      if (exp_q.size() == 0) begin
        abort_run($sformatf("UART sent character 0x%h when none was expected", got));
      end else begin
        check_value("uart character", got, exp_q.pop_front());
      end
    end
  end

  initial begin
    usb_rst     = 1'b1;
    enable_i    = 1'b0;
    change_i    = '0;
    ignore_i    = '0;
    send_i      = 1'b0;
    model_drops = 8'd0;
    seed        = 32'h82ac_8286;
    void'($urandom(seed));
    repeat (4) @(negedge clock);
    usb_rst = 1'b0;

    @(negedge clock);
    check_value("uart_tx_o", uart_tx_o, 1);
    check_value("dump_busy_o", dump_busy_o, 0);
    check_value("level_o", level_o, 0);
    check_value("drop_count_o", drop_count_o, 0);

    // Partial fill with enable toggling
    random_steps(400, 10);
    repeat (3) @(negedge clock);
    check_value("level_o", level_o, model_q.size());
    check_value("drop_count_o", drop_count_o, model_drops);
    run_dump(1'b0);

    // Overflow drops the later words
    random_steps(80, 1000);
    repeat (3) @(negedge clock);
    if (model_drops == 0) begin
      abort_run("Overflow stimulus caused no drops");
    end
    check_value("level_o", level_o, DEPTH);
    check_value("drop_count_o", drop_count_o, model_drops);
    run_dump(1'b1);

    run_dump(1'b0);  // An empty buffer gives no text at all
    check_value("drop_count_o", drop_count_o, model_drops);

    if (exp_q.size() == 0 && rx_q.size() == 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      abort_run("Characters were left unmatched at the end of the run");
    end
  end

endmodule

/* telem_pkg.sv */
package telem_pkg;

  // Log word layout
  localparam int LOG_WIDTH = 32;
  localparam int SIG_WIDTH = 20;  // Bits that trigger a capture
  localparam int IGN_WIDTH = LOG_WIDTH - SIG_WIDTH;  // Recorded only

  // Side bits sit above the change bits
  typedef struct packed {
    logic [IGN_WIDTH-1:0] ign;
    logic [SIG_WIDTH-1:0] chg;
  } log_word_t;

  // Hex dump engine
  typedef enum logic [1:0] {
    DUMP_IDLE = 2'd0,
    DUMP_REQ  = 2'd1,  // Ask the buffer for a word
    DUMP_EMIT = 2'd2,  // Eight hex digits, then CR LF
    DUMP_DONE = 2'd3   // Drain the UART
  } dump_state_e;

endpackage

/* tlm_buffer.sv */
`timescale 1ns/1ps
module tlm_buffer #(
  parameter int LOG_DEPTH = 512
) (
  input  logic                               clock,
  input  logic                               usb_rst,
  input  logic                               cap_valid_i,
  input  telem_pkg::log_word_t               cap_word_i,
  output logic                               cap_credit_o,
  input  logic                               rd_credit_i,
  output logic                               rd_valid_o,
  output telem_pkg::log_word_t               rd_word_o,
  output logic                               buf_empty_o,
  output logic [$clog2(LOG_DEPTH + 1)-1:0]   level_o
);

  localparam int AW = (LOG_DEPTH > 1) ? $clog2(LOG_DEPTH) : 1;
  localparam int CW = $clog2(LOG_DEPTH + 1);

  telem_pkg::log_word_t mem [LOG_DEPTH];  // Inferred block RAM

  logic [AW-1:0] wr_ptr_q;
  logic [AW-1:0] rd_ptr_q;
  logic [CW-1:0] count_q;
  logic          pend_q;
  logic          grant_w;
  logic          rd_en_w;

  assign grant_w     = pend_q || rd_credit_i;
  assign rd_en_w     = grant_w && (count_q != '0);
  assign buf_empty_o = (count_q == '0);
  assign level_o     = count_q;

  // RAM ports, write and registered read
  always_ff @(posedge clock) begin
    if (cap_valid_i) begin
      mem[wr_ptr_q] <= cap_word_i;
    end
    if (rd_en_w) begin
      rd_word_o <= mem[rd_ptr_q];
    end
  end

  always_ff @(posedge clock) begin
    if (usb_rst) begin
      wr_ptr_q     <= '0;
      rd_ptr_q     <= '0;
      count_q      <= '0;
      pend_q       <= 1'b0;
      rd_valid_o   <= 1'b0;
      cap_credit_o <= 1'b0;
    end else begin
      if (cap_valid_i) begin
        wr_ptr_q <= (wr_ptr_q == AW'(LOG_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (rd_en_w) begin
        rd_ptr_q <= (rd_ptr_q == AW'(LOG_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Capture side never overruns, its credits cover the depth
      count_q <= count_q + CW'(cap_valid_i) - CW'(rd_en_w);

      // Grant waits here until a word is available
      pend_q       <= grant_w && !rd_en_w;
      rd_valid_o   <= rd_en_w;
      cap_credit_o <= rd_en_w;  // Slot freed, hand it back upstream
    end
  end

endmodule

/* tlm_capture.sv */
`timescale 1ns/1ps
module tlm_capture #(
  parameter int LOG_DEPTH = 512
) (
  input  logic                           clock,
  input  logic                           usb_rst,
  input  logic                           enable_i,
  input  logic [telem_pkg::SIG_WIDTH-1:0] change_i,
  input  logic [telem_pkg::IGN_WIDTH-1:0] ignore_i,
  input  logic                           cap_credit_i,
  output logic                           cap_valid_o,
  output telem_pkg::log_word_t           cap_word_o,
  output logic [7:0]                     drop_count_o
);

  localparam int CW = $clog2(LOG_DEPTH + 1);

  logic                           en_q;
  logic [telem_pkg::SIG_WIDTH-1:0] chg_q;
  logic [telem_pkg::SIG_WIDTH-1:0] prev_q;
  logic [telem_pkg::IGN_WIDTH-1:0] ign_q;
  logic [CW-1:0]                  credit_q;
  logic                           hit_w;
  logic                           send_w;

  // Only the change field can trigger, side bits just ride along
  assign hit_w  = en_q && (chg_q != prev_q);
  assign send_w = hit_w && (credit_q != '0);

  // Input sampling and change reference
  always_ff @(posedge clock) begin
    if (usb_rst) begin
      en_q   <= 1'b0;
      chg_q  <= '0;
      prev_q <= '0;
    end else begin
      en_q   <= enable_i;
      chg_q  <= change_i;
      prev_q <= chg_q;  // Refreshed every cycle, enabled or not
    end
  end

  always_ff @(posedge clock) begin
    ign_q <= ignore_i;
    if (send_w) begin
      cap_word_o <= '{ign: ign_q, chg: chg_q};
    end
  end

  // Link A credits and drop counter
  always_ff @(posedge clock) begin
    if (usb_rst) begin
      cap_valid_o  <= 1'b0;
      credit_q     <= CW'(LOG_DEPTH);  // Whole buffer is free
      drop_count_o <= 8'd0;
    end else begin
      cap_valid_o <= send_w;
      credit_q    <= credit_q - CW'(send_w) + CW'(cap_credit_i);
      if (hit_w && !send_w && drop_count_o != 8'hFF) begin
        drop_count_o <= drop_count_o + 8'd1;  // Saturates
      end
    end
  end

endmodule

/* uart_tx.sv */
`timescale 1ns/1ps
module uart_tx #(
  parameter int BIT_CYCLES = 33
) (
  input  logic              clock,
  input  logic              usb_rst,
  input  logic              tx_valid_i,
  input  serial_pkg::byte_t tx_byte_i,
  output logic              tx_credit_o,
  output logic              tx_idle_o,
  output logic              uart_tx_o
);

  localparam int QD  = serial_pkg::UART_CREDITS;
  localparam int PW  = (QD > 1) ? $clog2(QD) : 1;
  localparam int BCW = $clog2(BIT_CYCLES + 1);

  serial_pkg::byte_t     hold_q [QD];  // Holding queue, one slot per credit
  logic [PW-1:0]         wr_q;
  logic [PW-1:0]         rd_q;
  logic [PW:0]           count_q;
  serial_pkg::tx_state_e state_q;
  serial_pkg::byte_t     shift_q;
  logic [BCW-1:0]        cyc_q;
  logic [2:0]            bit_q;
  logic                  bit_end_w;
  logic                  load_w;

  assign bit_end_w = (cyc_q == BCW'(BIT_CYCLES - 1));
  // Next byte enters straight after a stop bit, so frames run back to back
  assign load_w    = (count_q != '0) && ((state_q == serial_pkg::TX_IDLE) ||
                     (state_q == serial_pkg::TX_STOP && bit_end_w));
  assign tx_idle_o = (state_q == serial_pkg::TX_IDLE) && (count_q == '0);
  assign uart_tx_o = (state_q == serial_pkg::TX_START) ? 1'b0 :
                     (state_q == serial_pkg::TX_DATA)  ? shift_q[0] : 1'b1;

  always_ff @(posedge clock) begin
    if (tx_valid_i) begin
      hold_q[wr_q] <= tx_byte_i;
    end
    if (load_w) begin
      shift_q <= hold_q[rd_q];
    end else if (state_q == serial_pkg::TX_DATA && bit_end_w) begin
      shift_q <= shift_q >> 1;  // LSB first
    end
  end

  always_ff @(posedge clock) begin
    if (usb_rst) begin
      wr_q <= '0;
      rd_q <= '0;
      count_q <= '0;
      state_q <= serial_pkg::TX_IDLE;
      cyc_q <= '0;
      bit_q <= 3'd0;
      tx_credit_o <= 1'b0;
    end else begin
      if (tx_valid_i) wr_q <= (wr_q == PW'(QD - 1)) ? '0 : wr_q + 1'b1;
      if (load_w) rd_q <= (rd_q == PW'(QD - 1)) ? '0 : rd_q + 1'b1;
      count_q     <= count_q + (PW + 1)'(tx_valid_i) - (PW + 1)'(load_w);
      tx_credit_o <= load_w;  // Slot freed as the byte enters the shifter
      cyc_q       <= (bit_end_w || state_q == serial_pkg::TX_IDLE) ? '0 : cyc_q + 1'b1;

      case (state_q)
        serial_pkg::TX_IDLE:  if (load_w) state_q <= serial_pkg::TX_START;
        serial_pkg::TX_START: begin
          if (bit_end_w) begin
            state_q <= serial_pkg::TX_DATA;
            bit_q   <= 3'd0;
          end
        end
        serial_pkg::TX_DATA: begin
          if (bit_end_w) begin
            bit_q <= bit_q + 3'd1;
            if (bit_q == 3'd7) state_q <= serial_pkg::TX_STOP;
          end
        end
        default: begin
          if (bit_end_w) state_q <= load_w ? serial_pkg::TX_START : serial_pkg::TX_IDLE;
        end
      endcase
    end
  end

endmodule

/* usb_telemetry_core.sv */
`timescale 1ns/1ps
module usb_telemetry_core #(
  parameter int LOG_DEPTH  = 512,
  parameter int BIT_CYCLES = 33   // 60 MHz clock, fast debug UART
) (
  input  logic                             clock,
  input  logic                             usb_rst,
  input  logic                             enable_i,
  input  logic [telem_pkg::SIG_WIDTH-1:0]  change_i,
  input  logic [telem_pkg::IGN_WIDTH-1:0]  ignore_i,
  input  logic                             send_i,
  output logic                             dump_busy_o,
  output logic [$clog2(LOG_DEPTH + 1)-1:0] level_o,
  output logic [7:0]                       drop_count_o,
  output logic                             uart_tx_o
);

  // Link A, capture to buffer
  logic                 cap_valid;
  telem_pkg::log_word_t cap_word;
  logic                 cap_credit;

  // Link B, buffer to hex dump
  logic                 rd_valid;
  telem_pkg::log_word_t rd_word;
  logic                 rd_credit;
  logic                 buf_empty;

  // Link C, hex dump to UART
  logic                 tx_valid;
  serial_pkg::byte_t    tx_byte;
  logic                 tx_credit;
  logic                 tx_idle;

  tlm_capture #(.LOG_DEPTH(LOG_DEPTH)) u_capture (
    .clock, .usb_rst, .enable_i, .change_i, .ignore_i,
    .cap_credit_i(cap_credit),
    .cap_valid_o (cap_valid),
    .cap_word_o  (cap_word),
    .drop_count_o
  );

  tlm_buffer #(.LOG_DEPTH(LOG_DEPTH)) u_buffer (
    .clock, .usb_rst,
    .cap_valid_i (cap_valid),
    .cap_word_i  (cap_word),
    .cap_credit_o(cap_credit),
    .rd_credit_i (rd_credit),
    .rd_valid_o  (rd_valid),
    .rd_word_o   (rd_word),
    .buf_empty_o (buf_empty),
    .level_o
  );

  hex_dump u_hex_dump (
    .clock, .usb_rst, .send_i,
    .buf_empty_i(buf_empty), .rd_valid_i(rd_valid), .rd_word_i(rd_word),
    .rd_credit_o(rd_credit), .tx_credit_i(tx_credit), .tx_idle_i(tx_idle),
    .tx_valid_o (tx_valid),  .tx_byte_o(tx_byte),     .busy_o(dump_busy_o)
  );

  uart_tx #(.BIT_CYCLES(BIT_CYCLES)) u_uart_tx (
    .clock, .usb_rst,
    .tx_valid_i(tx_valid), .tx_byte_i(tx_byte), .tx_credit_o(tx_credit),
    .tx_idle_o (tx_idle),  .uart_tx_o
  );

endmodule
